// ==== hw/count_cfg_pkg.sv ====
`default_nettype none

package count_cfg_pkg;

    // lanes presented per clock cycle
    localparam int NUM_TAGS = 4;

    // timestamp width in ticks, comparisons wrap at 2^TAG_WIDTH
    localparam int TAG_WIDTH = 32;

    // width of the channel field carried with each tag
    localparam int CHANNEL_WIDTH = 4;

    // channels that are counted
    // any channel number at or above this is a keep-alive
    localparam int NUM_CHANNELS = 8;

    // width of one per-channel window count
    localparam int COUNTER_WIDTH = 16;

    // a partial sum must hold NUM_TAGS hits from one cycle
    localparam int SUM_WIDTH = $clog2(NUM_TAGS + 1);

    // whole tag cycles held in the input FIFO
    localparam int FIFO_DEPTH = 16;

    // FIFO address bits, depth is a power of two
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    // one timestamp
    typedef logic [TAG_WIDTH-1:0] tag_time_t;

    // one channel field
    typedef logic [CHANNEL_WIDTH-1:0] channel_t;

endpackage

`default_nettype wire

// ==== hw/count_types_pkg.sv ====
`default_nettype none

package count_types_pkg;

    // tracker FSM
    // idle until start, armed until the first head, then measuring until rst
    typedef enum logic [1:0] {
        TRACK_IDLE,
        TRACK_ARMED,
        TRACK_MEASURE
    } track_state_e;

    // which window a lane is counted into on this cycle
    typedef enum logic [1:0] {
        LANE_NONE,
        LANE_CURRENT,
        LANE_NEXT
    } lane_class_e;

endpackage

`default_nettype wire

// ==== hw/tag_fifo.sv ====
`default_nettype none

module tag_fifo
    import count_cfg_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [NUM_TAGS-1:0] tag_valid_i,
    input  tag_time_t           tag_time_i [NUM_TAGS],
    input  channel_t            tag_channel_i [NUM_TAGS],
    input  logic                rd_en_i,
    output logic                fifo_valid_o,
    output logic [NUM_TAGS-1:0] head_valid_o,
    output tag_time_t           head_time_o [NUM_TAGS],
    output channel_t            head_channel_o [NUM_TAGS],
    output logic                full_o
);

    // input register stage
    logic                wr_req;
    logic [NUM_TAGS-1:0] in_valid;
    tag_time_t           in_time [NUM_TAGS];
    channel_t            in_channel [NUM_TAGS];

    // storage, one entry per tag cycle
    logic [NUM_TAGS-1:0] mem_valid [FIFO_DEPTH];
    tag_time_t           mem_time [FIFO_DEPTH][NUM_TAGS];
    channel_t            mem_channel [FIFO_DEPTH][NUM_TAGS];

    logic [FIFO_AW-1:0]  wr_ptr;
    logic [FIFO_AW-1:0]  rd_ptr;
    logic [FIFO_AW:0]    occupancy;
    logic                wr_en;
    logic                rd_en;

    // only cycles with at least one valid lane are worth storing
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_req <= 1'b0;
        end else begin
            wr_req <= |tag_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        in_valid   <= tag_valid_i;
        in_time    <= tag_time_i;
        in_channel <= tag_channel_i;
    end

    assign full_o       = (occupancy == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign fifo_valid_o = (occupancy != '0);

    // a write into a full FIFO is dropped
    assign wr_en = wr_req && !full_o;
    assign rd_en = fifo_valid_o && rd_en_i;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_valid[wr_ptr]   <= in_valid;
            mem_time[wr_ptr]    <= in_time;
            mem_channel[wr_ptr] <= in_channel;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // first-word-fall-through, head entry shown without a read
    assign head_valid_o   = mem_valid[rd_ptr];
    assign head_time_o    = mem_time[rd_ptr];
    assign head_channel_o = mem_channel[rd_ptr];

endmodule

`default_nettype wire

// ==== hw/window_tracker.sv ====
`default_nettype none

module window_tracker
    import count_cfg_pkg::*;
    import count_types_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                start_counting_i,
    input  tag_time_t           window_size_i,
    input  logic                fifo_valid_i,
    input  logic [NUM_TAGS-1:0] head_valid_i,
    input  tag_time_t           head_time_i [NUM_TAGS],
    input  channel_t            head_channel_i [NUM_TAGS],
    output logic                fifo_rd_en_o,
    output lane_class_e         lane_class_o [NUM_TAGS],
    output channel_t            lane_channel_o [NUM_TAGS],
    output logic                update_window_o
);

    track_state_e        state;
    logic                rd_en_q;
    logic                replay;
    logic                consume;
    logic                active;

    // window bounds, current window is [window_end - size, window_end)
    tag_time_t           window_end;
    tag_time_t           next_window_end;
    tag_time_t           bound_end;
    tag_time_t           bound_next;
    tag_time_t           first_time;

    // copy of the last consumed head, replayed while reading is stalled
    logic [NUM_TAGS-1:0] hold_valid;
    tag_time_t           hold_time [NUM_TAGS];
    channel_t            hold_channel [NUM_TAGS];

    logic [NUM_TAGS-1:0] mux_valid;
    tag_time_t           mux_time [NUM_TAGS];
    tag_time_t           diff_end [NUM_TAGS];
    tag_time_t           diff_next [NUM_TAGS];
    logic [NUM_TAGS-1:0] lane_on;
    logic [NUM_TAGS-1:0] before_end;
    logic [NUM_TAGS-1:0] before_next;
    logic                update;
    logic                far_ahead;

    // a low read enable means the held cycle is being replayed
    assign replay  = !rd_en_q;
    assign consume = fifo_valid_i && rd_en_q;

    // lanes take part only once armed, the arming head itself included
    always_comb begin
        active = 1'b0;
        if (state == TRACK_ARMED) begin
            active = consume;
        end else if (state == TRACK_MEASURE) begin
            active = consume || replay;
        end
    end

    // lowest-indexed valid lane opens the first window
    always_comb begin
        first_time = head_time_i[0];
        for (int i = NUM_TAGS - 1; i >= 0; i--) begin
            if (head_valid_i[i]) begin
                first_time = head_time_i[i];
            end
        end
    end

    // while armed the bounds come straight from the head so that
    // the first cycle is classified like any other
    always_comb begin
        if (state == TRACK_MEASURE) begin
            bound_end  = window_end;
            bound_next = next_window_end;
        end else begin
            bound_end  = first_time + window_size_i;
            bound_next = first_time + (window_size_i << 1);
        end
    end

    always_comb begin
        mux_valid = replay ? hold_valid : head_valid_i;
        for (int i = 0; i < NUM_TAGS; i++) begin
            mux_time[i]       = replay ? hold_time[i] : head_time_i[i];
            lane_channel_o[i] = replay ? hold_channel[i] : head_channel_i[i];
        end
    end

    // wrapping differences, a set sign bit means the lane lies before the bound
    always_comb begin
        update    = 1'b0;
        far_ahead = 1'b0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            diff_end[i]     = mux_time[i] - bound_end;
            diff_next[i]    = mux_time[i] - bound_next;
            before_end[i]   = diff_end[i][TAG_WIDTH-1];
            before_next[i]  = diff_next[i][TAG_WIDTH-1];
            lane_on[i]      = mux_valid[i] && active;
            lane_class_o[i] = LANE_NONE;
            if (lane_on[i]) begin
                if (before_end[i]) begin
                    // current window only when first consumed, a replay would recount it
                    if (!replay) begin
                        lane_class_o[i] = LANE_CURRENT;
                    end
                end else begin
                    update = 1'b1;
                    if (before_next[i]) begin
                        lane_class_o[i] = LANE_NEXT;
                    end else begin
                        far_ahead = 1'b1;
                    end
                end
            end
        end
    end

    assign update_window_o = update;
    assign fifo_rd_en_o    = rd_en_q;

    // stall while some lane is two or more windows ahead
    // the replay that advances last also lets reading resume
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TRACK_IDLE;
            rd_en_q <= 1'b1;
        end else begin
            rd_en_q <= !far_ahead;
            case (state)
                TRACK_IDLE: begin
                    if (start_counting_i) begin
                        state <= TRACK_ARMED;
                    end
                end
                TRACK_ARMED: begin
                    if (consume) begin
                        state <= TRACK_MEASURE;
                    end
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    // both bounds step by one window on each advance
    always_ff @(posedge clk) begin
        if (active) begin
            window_end      <= update ? bound_next : bound_end;
            next_window_end <= update ? bound_next + window_size_i : bound_next;
        end
    end

    always_ff @(posedge clk) begin
        if (consume) begin
            hold_valid   <= head_valid_i;
            hold_time    <= head_time_i;
            hold_channel <= head_channel_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/lane_binner.sv ====
`default_nettype none

module lane_binner
    import count_cfg_pkg::*;
    import count_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  lane_class_e          lane_class_i [NUM_TAGS],
    input  channel_t             lane_channel_i [NUM_TAGS],
    output logic [SUM_WIDTH-1:0] cur_sum_o [NUM_CHANNELS],
    output logic [SUM_WIDTH-1:0] next_sum_o [NUM_CHANNELS]
);

    // one bit per lane for each channel and target window
    logic [NUM_TAGS-1:0] cur_hits [NUM_CHANNELS];
    logic [NUM_TAGS-1:0] next_hits [NUM_CHANNELS];

    function automatic logic [SUM_WIDTH-1:0] popcount(input logic [NUM_TAGS-1:0] bits);
        logic [SUM_WIDTH-1:0] n;
        n = '0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            n = n + SUM_WIDTH'(bits[i]);
        end
        return n;
    endfunction

    // stage 1 decodes the channel of each lane
    // keep-alive channels match no counted channel and drop out here
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_hits  <= '{default: '0};
            next_hits <= '{default: '0};
        end else begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                for (int i = 0; i < NUM_TAGS; i++) begin
                    cur_hits[c][i]  <= (int'(lane_channel_i[i]) == c)
                                       && (lane_class_i[i] == LANE_CURRENT);
                    next_hits[c][i] <= (int'(lane_channel_i[i]) == c)
                                       && (lane_class_i[i] == LANE_NEXT);
                end
            end
        end
    end

    // stage 2 turns the hits of each channel into counts
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_sum_o  <= '{default: '0};
            next_sum_o <= '{default: '0};
        end else begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                cur_sum_o[c]  <= popcount(cur_hits[c]);
                next_sum_o[c] <= popcount(next_hits[c]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rate_counters.sv ====
`default_nettype none

module rate_counters
    import count_cfg_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     update_window_i,
    input  logic [SUM_WIDTH-1:0]     cur_sum_i [NUM_CHANNELS],
    input  logic [SUM_WIDTH-1:0]     next_sum_i [NUM_CHANNELS],
    output logic [COUNTER_WIDTH-1:0] count_data_o [NUM_CHANNELS],
    output logic                     count_valid_o
);

    // advance delayed to line up with the binner output
    logic update_d1;
    logic update_d2;
    logic valid_q;

    logic [COUNTER_WIDTH-1:0] counter [NUM_CHANNELS];
    logic [COUNTER_WIDTH-1:0] total [NUM_CHANNELS];

    // running count with this cycle's current-window hits folded in
    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            total[c] = counter[c] + COUNTER_WIDTH'(cur_sum_i[c]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            update_d1 <= 1'b0;
            update_d2 <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            update_d1 <= update_window_i;
            update_d2 <= update_d1;
            valid_q   <= update_d2;
        end
    end

    // on a window close the counter restarts with the tags that
    // already belong to the following window
    always_ff @(posedge clk) begin
        if (rst) begin
            counter <= '{default: '0};
        end else begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                counter[c] <= update_d2 ? COUNTER_WIDTH'(next_sum_i[c]) : total[c];
            end
        end
    end

    // report held until the next window closes
    always_ff @(posedge clk) begin
        if (update_d2) begin
            count_data_o <= total;
        end
    end

    assign count_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== hw/countrate_top.sv ====
`default_nettype none

module countrate_top
    import count_cfg_pkg::*;
    import count_types_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [NUM_TAGS-1:0]      tag_valid_i,
    input  tag_time_t                tag_time_i [NUM_TAGS],
    input  channel_t                 tag_channel_i [NUM_TAGS],
    input  tag_time_t                window_size_i,
    input  logic                     start_counting_i,
    output logic [COUNTER_WIDTH-1:0] count_data_o [NUM_CHANNELS],
    output logic                     count_valid_o
);

    // FIFO head towards the tracker
    logic                 fifo_valid;
    logic [NUM_TAGS-1:0]  head_valid;
    tag_time_t            head_time [NUM_TAGS];
    channel_t             head_channel [NUM_TAGS];
    logic                 fifo_full;
    logic                 fifo_rd_en;

    // classified lanes and window advance
    lane_class_e          lane_class [NUM_TAGS];
    channel_t             lane_channel [NUM_TAGS];
    logic                 update_window;

    // per-channel partial sums
    logic [SUM_WIDTH-1:0] cur_sum [NUM_CHANNELS];
    logic [SUM_WIDTH-1:0] next_sum [NUM_CHANNELS];

    tag_fifo u_fifo (
        .clk            (clk),
        .rst            (rst),
        .tag_valid_i    (tag_valid_i),
        .tag_time_i     (tag_time_i),
        .tag_channel_i  (tag_channel_i),
        .rd_en_i        (fifo_rd_en),
        .fifo_valid_o   (fifo_valid),
        .head_valid_o   (head_valid),
        .head_time_o    (head_time),
        .head_channel_o (head_channel),
        .full_o         (fifo_full)
    );

    window_tracker u_tracker (
        .clk              (clk),
        .rst              (rst),
        .start_counting_i (start_counting_i),
        .window_size_i    (window_size_i),
        .fifo_valid_i     (fifo_valid),
        .head_valid_i     (head_valid),
        .head_time_i      (head_time),
        .head_channel_i   (head_channel),
        .fifo_rd_en_o     (fifo_rd_en),
        .lane_class_o     (lane_class),
        .lane_channel_o   (lane_channel),
        .update_window_o  (update_window)
    );

    lane_binner u_binner (
        .clk            (clk),
        .rst            (rst),
        .lane_class_i   (lane_class),
        .lane_channel_i (lane_channel),
        .cur_sum_o      (cur_sum),
        .next_sum_o     (next_sum)
    );

    rate_counters u_counters (
        .clk             (clk),
        .rst             (rst),
        .update_window_i (update_window),
        .cur_sum_i       (cur_sum),
        .next_sum_i      (next_sum),
        .count_data_o    (count_data_o),
        .count_valid_o   (count_valid_o)
    );

endmodule

`default_nettype wire

// ==== sim/countrate_chk.sv ====
`default_nettype none

module countrate_chk
    import count_types_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         count_valid_i,
    input logic         update_window_i,
    input logic         fifo_rd_en_i,
    input logic         fifo_full_i,
    input logic         fifo_wr_req_i,
    input track_state_e state_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // failed assertions so far, summed into the closing line of the testbench
    int fail_count = 0;

    // a report only comes out of a running measurement
    a_valid_in_measure: assert property (@(posedge clk) disable iff (rst)
        count_valid_i |-> (state_i == TRACK_MEASURE))
    else begin
        $error("count_valid_o high while the tracker is not measuring");
        fail_count++;
    end

    // source rate must stay below what the FIFO absorbs
    a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        fifo_wr_req_i |-> !fifo_full_i)
    else begin
        $error("tag FIFO written while full, a tag cycle was lost");
        fail_count++;
    end

    // stalls only happen once the windows are running
    a_stall_in_measure: assert property (@(posedge clk) disable iff (rst)
        !fifo_rd_en_i |-> (state_i == TRACK_MEASURE))
    else begin
        $error("FIFO read stalled outside TRACK_MEASURE");
        fail_count++;
    end

    // advance to strobe is a fixed three-cycle pipe
    a_strobe_after_advance: assert property (@(posedge clk) disable iff (rst)
        update_window_i |-> ##3 count_valid_i)
    else begin
        $error("count_valid_o missing three cycles after a window advance");
        fail_count++;
    end

    a_strobe_has_advance: assert property (@(posedge clk) disable iff (rst)
        count_valid_i |-> $past(update_window_i, 3))
    else begin
        $error("count_valid_o without a window advance three cycles before");
        fail_count++;
    end

endmodule

bind countrate_top countrate_chk u_chk (
    .clk             (clk),
    .rst             (rst),
    .count_valid_i   (count_valid_o),
    .update_window_i (update_window),
    .fifo_rd_en_i    (fifo_rd_en),
    .fifo_full_i     (fifo_full),
    .fifo_wr_req_i   (u_fifo.wr_req),
    .state_i         (u_tracker.state)
);

`default_nettype wire

// ==== sim/countrate_tb.sv ====
`default_nettype none

module countrate_tb
    import count_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED_INIT      = 32'h1b4e_5cb7;
    localparam int RESET_CYCLES   = 16;
    localparam int PRE_CYCLES     = 8;
    localparam int TRAFFIC_CYCLES = 150;
    localparam int SHORT_CYCLES   = 60;
    localparam int DRAIN_CYCLES   = 400;
    localparam int SETTLE_CYCLES  = 20;
    localparam int NUM_TESTS      = 6;
    localparam int MARGIN         = 2;
    localparam int GAP_MASK       = 15;
    localparam int MAX_WIN        = 256;
    localparam int KEEPALIVE_CH   = 12;

    // window sizes in ticks, one per test
    localparam tag_time_t WIN_PRESTART = 100;
    localparam tag_time_t WIN_RANDOM   = 37;
    localparam tag_time_t WIN_STRADDLE = 64;
    localparam tag_time_t WIN_GAP      = 50;
    localparam tag_time_t WIN_WRAP     = 100;
    localparam tag_time_t WIN_RESTART  = 80;
    // close enough below 2^32 that the wrap test rolls over early
    localparam tag_time_t WRAP_START   = 32'hffff_fc00;

    // each valid cycle takes up to three clocks with its idle gap
    localparam int TOTAL_TRAFFIC = PRE_CYCLES + 4 * TRAFFIC_CYCLES + 5 * SHORT_CYCLES;
    localparam int WATCHDOG_CYCLES = MARGIN * (3 * TOTAL_TRAFFIC
        + NUM_TESTS * (DRAIN_CYCLES + SETTLE_CYCLES + 2 * RESET_CYCLES + 20));

    logic                     clk = 1'b0;
    logic                     rst;
    logic [NUM_TAGS-1:0]      tag_valid_i;
    tag_time_t                tag_time_i [NUM_TAGS];
    channel_t                 tag_channel_i [NUM_TAGS];
    tag_time_t                window_size_i;
    logic                     start_counting_i;
    logic [COUNTER_WIDTH-1:0] count_data_o [NUM_CHANNELS];
    logic                     count_valid_o;

    // stimulus state
    int                  seed;
    string               test_name;
    tag_time_t           cur_time;
    logic [NUM_TAGS-1:0] lane_valid;
    tag_time_t           lane_time [NUM_TAGS];
    channel_t            lane_chan [NUM_TAGS];

    // reference model, owned by the stimulus process
    logic                counting;
    logic                started;
    tag_time_t           win_start;
    int                  max_k;
    int                  exp_cnt [MAX_WIN][NUM_CHANNELS];
    int                  tb_errors = 0;

    // scoreboard state, owned by the scoreboard process
    int                  rep_idx = 0;
    int                  sb_errors = 0;

    countrate_top DUT (
        .clk              (clk),
        .rst              (rst),
        .tag_valid_i      (tag_valid_i),
        .tag_time_i       (tag_time_i),
        .tag_channel_i    (tag_channel_i),
        .window_size_i    (window_size_i),
        .start_counting_i (start_counting_i),
        .count_data_o     (count_data_o),
        .count_valid_o    (count_valid_o)
    );

    always #10 clk = ~clk;

    task automatic clear_model();
        counting = 1'b0;
        started  = 1'b0;
        max_k    = 0;
        for (int k = 0; k < MAX_WIN; k++) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                exp_cnt[k][c] = 0;
            end
        end
    endtask

    // window k covers [start + k*W, start + (k+1)*W), offsets wrap at 2^32
    task automatic record_tag(input tag_time_t t, input channel_t ch);
        tag_time_t off;
        int        k;
        if (!started) begin
            started   = 1'b1;
            win_start = t;
        end
        off = t - win_start;
        k   = int'(off / window_size_i);
        if (k >= MAX_WIN) begin
            tb_errors++;
            $display("%s: tag lies beyond the window range of the model", test_name);
        end else begin
            if (int'(ch) < NUM_CHANNELS) begin
                exp_cnt[k][int'(ch)]++;
            end
            // keep-alives still close windows
            if (k > max_k) begin
                max_k = k;
            end
        end
    endtask

    task automatic send_cycle();
        @(negedge clk);
        tag_valid_i = lane_valid;
        for (int i = 0; i < NUM_TAGS; i++) begin
            tag_time_i[i]    = lane_valid[i] ? lane_time[i] : '0;
            tag_channel_i[i] = lane_valid[i] ? lane_chan[i] : '0;
            if (lane_valid[i] && counting) begin
                record_tag(lane_time[i], lane_chan[i]);
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            tag_valid_i = '0;
        end
    endtask

    // times rise across lanes, channels 8 and 9 act as keep-alives
    task automatic random_cycle(input bit multi);
        int pick;
        if (multi) begin
            lane_valid = NUM_TAGS'($random(seed));
            if (lane_valid == '0) begin
                lane_valid = NUM_TAGS'(1);
            end
        end else begin
            pick       = $random(seed) & (NUM_TAGS - 1);
            lane_valid = NUM_TAGS'(1) << pick;
        end
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (lane_valid[i]) begin
                cur_time     = cur_time + tag_time_t'(1 + ($random(seed) & GAP_MASK));
                lane_time[i] = cur_time;
                lane_chan[i] = channel_t'($unsigned($random(seed)) % 10);
            end
        end
        send_cycle();
        // at least one idle cycle keeps the FIFO from filling
        idle_cycles(1 + ($random(seed) & 1));
    endtask

    // mode 0 single lane, 1 multi lane, 2 mixed
    task automatic random_traffic(input int n, input int mode);
        bit multi;
        for (int j = 0; j < n; j++) begin
            multi = (mode == 2) ? bit'($random(seed) & 1) : bit'(mode);
            random_cycle(multi);
        end
    endtask

    task automatic start_measure(input tag_time_t w);
        @(negedge clk);
        window_size_i    = w;
        start_counting_i = 1'b1;
        @(negedge clk);
        start_counting_i = 1'b0;
        counting         = 1'b1;
    endtask

    // model cleared only once rst has already silenced count_valid_o
    task automatic apply_reset();
        @(negedge clk);
        rst              = 1'b1;
        tag_valid_i      = '0;
        start_counting_i = 1'b0;
        @(negedge clk);
        clear_model();
        repeat (RESET_CYCLES - 1) @(negedge clk);
        rst = 1'b0;
    endtask

    // rep_idx moves on falling edges, so it is read on rising ones
    task automatic drain_measure();
        int waited;
        waited = 0;
        while (rep_idx < max_k && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (rep_idx < max_k) begin
            tb_errors++;
            $display("%s: timed out waiting for window reports, %0d of %0d arrived",
                     test_name, rep_idx, max_k);
        end
        repeat (SETTLE_CYCLES) @(posedge clk);
        assert (rep_idx == max_k) else begin
            tb_errors++;
            $display("** Error %s: report count expected %0d actual %0d",
                     test_name, max_k, rep_idx);
        end
    endtask

    // compares each report with the oldest window not yet reported
    always @(negedge clk) begin
        if (rst) begin
            rep_idx = 0;
        end else if (count_valid_o) begin
            if (!started || rep_idx >= max_k) begin
                sb_errors++;
                $display("%s: a report arrived for a window that has not closed", test_name);
            end else begin
                for (int c = 0; c < NUM_CHANNELS; c++) begin
                    assert (count_data_o[c] == COUNTER_WIDTH'(exp_cnt[rep_idx][c])) else begin
                        sb_errors++;
                        $display("** Error %s: window %0d channel %0d expected %0d actual %0d",
                                 test_name, rep_idx, c, exp_cnt[rep_idx][c], count_data_o[c]);
                    end
                end
            end
            rep_idx++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        int total;
        seed             = SEED_INIT;
        rst              = 1'b1;
        tag_valid_i      = '0;
        window_size_i    = WIN_PRESTART;
        start_counting_i = 1'b0;
        cur_time         = 32'h0000_1000;
        lane_valid       = '0;
        test_name        = "reset";
        for (int i = 0; i < NUM_TAGS; i++) begin
            tag_time_i[i]    = '0;
            tag_channel_i[i] = '0;
            lane_time[i]     = '0;
            lane_chan[i]     = '0;
        end
        clear_model();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        // tags ahead of the start drain through the idle tracker uncounted
        test_name = "prestart";
        random_traffic(PRE_CYCLES, 1);
        idle_cycles(12);
        start_measure(WIN_PRESTART);
        random_traffic(TRAFFIC_CYCLES, 2);
        drain_measure();

        test_name = "random";
        apply_reset();
        start_measure(WIN_RANDOM);
        random_traffic(TRAFFIC_CYCLES, 0);
        random_traffic(TRAFFIC_CYCLES, 1);
        drain_measure();

        // second cycle has two lanes either side of the first boundary
        test_name = "straddle";
        apply_reset();
        start_measure(WIN_STRADDLE);
        lane_valid   = NUM_TAGS'(1);
        cur_time     = cur_time + 5;
        lane_time[0] = cur_time;
        lane_chan[0] = channel_t'(3);
        send_cycle();
        idle_cycles(2);
        lane_valid = '1;
        for (int i = 0; i < NUM_TAGS; i++) begin
            lane_time[i] = win_start + WIN_STRADDLE - 2 + tag_time_t'(i);
            lane_chan[i] = channel_t'(i + 1);
        end
        cur_time = lane_time[NUM_TAGS-1];
        send_cycle();
        idle_cycles(2);
        random_traffic(SHORT_CYCLES, 2);
        drain_measure();

        // lone keep-alive several windows ahead, then a further jump
        test_name = "gap";
        apply_reset();
        start_measure(WIN_GAP);
        random_traffic(SHORT_CYCLES, 1);
        cur_time     = cur_time + 5 * WIN_GAP;
        lane_valid   = NUM_TAGS'(2);
        lane_time[1] = cur_time;
        lane_chan[1] = channel_t'(KEEPALIVE_CH);
        send_cycle();
        idle_cycles(4);
        cur_time = cur_time + 3 * WIN_GAP;
        random_traffic(SHORT_CYCLES, 2);
        drain_measure();

        test_name = "wrap";
        apply_reset();
        cur_time = WRAP_START;
        start_measure(WIN_WRAP);
        random_traffic(TRAFFIC_CYCLES, 2);
        drain_measure();

        // rst lands while tags are still queued, then a fresh start
        test_name = "restart";
        apply_reset();
        start_measure(WIN_RESTART);
        random_traffic(SHORT_CYCLES, 2);
        apply_reset();
        start_measure(WIN_RESTART);
        random_traffic(SHORT_CYCLES, 2);
        drain_measure();

        total = tb_errors + sb_errors + DUT.u_chk.fail_count;
        $display("summary: %0d model, %0d scoreboard, %0d assertion failures",
                 tb_errors, sb_errors, DUT.u_chk.fail_count);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/count_cfg_pkg.sv
hw/count_types_pkg.sv
hw/tag_fifo.sv
hw/window_tracker.sv
hw/lane_binner.sv
hw/rate_counters.sv
hw/countrate_top.sv
sim/countrate_chk.sv
sim/countrate_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the count-rate testbench with Verilator, run it, search the log
LOG=sim.log

verilator --binary --assert --timescale 1ns/100ps -f sim.f \
    --top-module countrate_tb -o countrate_sim \
    && ./obj_dir/countrate_sim +verilator+error+limit+1000 > "$LOG" 2>&1 \
    || echo "build or simulation returned a failing status"

grep -qx "No errors" "$LOG" \
    && echo "PASS" \
    || { echo "FAIL, see $LOG"; exit 1; }
